// File: rtl/fir_pkg.sv
// FIR subsystem shared definitions
// sample and coefficient widths, the coefficient array type,
// the default low-pass tap set and the adder-tree depth helper

package fir_pkg;

    localparam int SAMPLE_W = 16;
    localparam int COEF_W   = 18;
    localparam int MAX_TAPS = 32;

    // entries past the tap count are ignored
    typedef int coef_arr_t[MAX_TAPS];

    // 8-tap symmetric low-pass, coefficient sum 64800 (about unity for a 16-bit shift)
    localparam coef_arr_t DEFAULT_COEF = '{
        0: 1200,
        1: -3400,
        2: 9800,
        3: 24800,
        4: 24800,
        5: 9800,
        6: -3400,
        7: 1200,
        default: 0
    };

    // number of pairwise adder levels needed to reduce n products to one
    function automatic int clog2_f(input int n);
        int stages;
        int span;
        stages = 0;
        span   = 1;
        while (span < n) begin
            span   = span * 2;
            stages = stages + 1;
        end
        return stages;
    endfunction

endpackage

// File: rtl/shift_reg.sv
// Delay line of DELAY register stages
// advances on en_i; reset of the stages is optional so wide data
// paths can be built without a reset tree

`timescale 1ns/10ps

module shift_reg #(
    parameter int DATA_WIDTH = 1,
    parameter int DELAY      = 1,
    parameter bit RESET_EN   = 1'b1
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  en_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [DATA_WIDTH-1:0] data_o
);

    logic [DATA_WIDTH-1:0] stage[DELAY];

    if (RESET_EN) begin : g_rst
        always_ff @(posedge clk_i) begin
            if (!rstn_i) begin
                for (int i = 0; i < DELAY; i++) begin
                    stage[i] <= '0;
                end
            end else if (en_i) begin
                stage[0] <= data_i;
                for (int i = 1; i < DELAY; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end
    end else begin : g_no_rst
        always_ff @(posedge clk_i) begin
            if (en_i) begin
                stage[0] <= data_i;
                for (int i = 1; i < DELAY; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end
    end

    assign data_o = stage[DELAY-1];

endmodule

// File: rtl/fir_filter.sv
// Streaming FIR filter core
// tapped delay line loaded on accepted samples, one registered
// multiplier per tap and a registered binary adder tree
// output is the full-precision sum, 2 + tree levels cycles after acceptance

`timescale 1ns/10ps

module fir_filter
    import fir_pkg::*;
#(
    parameter int        TAP_NUM = 8,
    parameter coef_arr_t COEF    = DEFAULT_COEF
) (
    input logic clk_i,
    input logic rstn_i,
    input logic en_i,

    input logic                       tvalid_i,
    input logic signed [SAMPLE_W-1:0] tdata_i,

    output logic                                                  tvalid_o,
    output logic signed [SAMPLE_W+COEF_W+clog2_f(TAP_NUM)-1:0] tdata_o
);

    localparam int LEVELS = clog2_f(TAP_NUM);
    localparam int ACC_W  = SAMPLE_W + COEF_W + LEVELS;
    localparam int LAT    = 2 + LEVELS;

    logic                       accept;
    logic signed [SAMPLE_W-1:0] delay[TAP_NUM];

    // node[0] holds the products, node[l] the sums of tree level l
    logic signed [ACC_W-1:0]    node [LEVELS+1][TAP_NUM];

    assign accept = tvalid_i & en_i;

    // valid flag follows the free-running pipeline
    shift_reg #(
        .DATA_WIDTH(1),
        .DELAY     (LAT),
        .RESET_EN  (1'b1)
    ) u_valid_dly (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (1'b1),
        .data_i(accept),
        .data_o(tvalid_o)
    );

    // delay line only moves on accepted samples
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < TAP_NUM; k++) begin
                delay[k] <= '0;
            end
        end else if (accept) begin
            delay[0] <= tdata_i;
            for (int k = 1; k < TAP_NUM; k++) begin
                delay[k] <= delay[k-1];
            end
        end
    end

    for (genvar k = 0; k < TAP_NUM; k++) begin : g_tap
        localparam logic signed [COEF_W-1:0] C = COEF_W'(COEF[k]);

        always_ff @(posedge clk_i) begin
            node[0][k] <= ACC_W'(delay[k]) * ACC_W'(C);  // operands widened first
        end
    end

    for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
        localparam int N_IN  = (TAP_NUM + (1 << (lvl - 1)) - 1) >> (lvl - 1);
        localparam int N_OUT = (N_IN + 1) / 2;

        for (genvar i = 0; i < N_OUT; i++) begin : g_node
            if (2 * i + 1 < N_IN) begin : g_pair
                always_ff @(posedge clk_i) begin
                    node[lvl][i] <= node[lvl-1][2*i] + node[lvl-1][2*i+1];
                end
            end else begin : g_odd
                // last node of an odd level pairs with zero
                always_ff @(posedge clk_i) begin
                    node[lvl][i] <= node[lvl-1][2*i];
                end
            end
        end
    end

    assign tdata_o = node[LEVELS][0];

endmodule

// File: rtl/fir_requant.sv
// Output requantizer
// rounds half up, shifts right by SHIFT and saturates to the sample
// width in one registered stage; sat_o marks clipped samples

`timescale 1ns/10ps

module fir_requant
    import fir_pkg::*;
#(
    parameter int TAP_NUM = 8,
    parameter int SHIFT   = 16
) (
    input logic clk_i,
    input logic rstn_i,

    input logic                                                  tvalid_i,
    input logic signed [SAMPLE_W+COEF_W+clog2_f(TAP_NUM)-1:0] tdata_i,

    output logic                       tvalid_o,
    output logic                       sat_o,
    output logic signed [SAMPLE_W-1:0] tdata_o
);

    localparam int ACC_W = SAMPLE_W + COEF_W + clog2_f(TAP_NUM);
    localparam int RND_W = ACC_W + 1;  // headroom so the rounding add cannot wrap

    localparam logic signed [RND_W-1:0] HALF = RND_W'(1) << (SHIFT - 1);

    localparam logic signed [SAMPLE_W-1:0] OUT_MAX = {1'b0, {(SAMPLE_W - 1) {1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] OUT_MIN = {1'b1, {(SAMPLE_W - 1) {1'b0}}};
    localparam logic signed [RND_W-1:0]    LIM_MAX = RND_W'(OUT_MAX);
    localparam logic signed [RND_W-1:0]    LIM_MIN = RND_W'(OUT_MIN);

    logic signed [RND_W-1:0]    rounded;
    logic signed [RND_W-1:0]    shifted;
    logic                       over;
    logic                       under;
    logic signed [SAMPLE_W-1:0] clamped;

    assign rounded = RND_W'(tdata_i) + HALF;
    assign shifted = rounded >>> SHIFT;

    always_comb begin
        over  = shifted > LIM_MAX;
        under = shifted < LIM_MIN;
        if (over) begin
            clamped = OUT_MAX;
        end else if (under) begin
            clamped = OUT_MIN;
        end else begin
            clamped = shifted[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tvalid_o <= 1'b0;
            sat_o    <= 1'b0;
        end else begin
            tvalid_o <= tvalid_i;
            sat_o    <= tvalid_i & (over | under);  // only flagged with a valid sample
        end
        tdata_o <= clamped;
    end

endmodule

// File: rtl/fir_top.sv
// FIR subsystem top level
// filter core followed by the requantizer; 16-bit signed stream in
// and out with a valid flag, a global enable and a clip flag
// latency is 3 + tree levels cycles, 6 for 8 taps

`timescale 1ns/10ps

module fir_top
    import fir_pkg::*;
#(
    parameter int        TAP_NUM = 8,
    parameter coef_arr_t COEF    = DEFAULT_COEF,
    parameter int        SHIFT   = 16
) (
    input logic clk_i,
    input logic rstn_i,
    input logic en_i,

    input logic                       tvalid_i,
    input logic signed [SAMPLE_W-1:0] tdata_i,

    output logic                       tvalid_o,
    output logic signed [SAMPLE_W-1:0] tdata_o,
    output logic                       sat_o
);

    localparam int ACC_W = SAMPLE_W + COEF_W + clog2_f(TAP_NUM);

    logic                    acc_valid;
    logic signed [ACC_W-1:0] acc_data;  // full-precision filter sum

    fir_filter #(
        .TAP_NUM(TAP_NUM),
        .COEF   (COEF)
    ) u_filter (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (en_i),
        .tvalid_i(tvalid_i),
        .tdata_i (tdata_i),
        .tvalid_o(acc_valid),
        .tdata_o (acc_data)
    );

    fir_requant #(
        .TAP_NUM(TAP_NUM),
        .SHIFT  (SHIFT)
    ) u_requant (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .tvalid_i(acc_valid),
        .tdata_i (acc_data),
        .tvalid_o(tvalid_o),
        .sat_o   (sat_o),
        .tdata_o (tdata_o)
    );

endmodule

// File: sim/fir_assertions.sv
// Stream timing assertions for the FIR subsystem
// bound into fir_top; checks output valid against accepted samples,
// reset behaviour and the clip flag

`timescale 1ns/10ps

module fir_assertions #(
    parameter int LATENCY = 6
) (
    input logic clk_i,
    input logic rstn_i,
    input logic en_i,
    input logic tvalid_i,
    input logic out_valid_i,
    input logic out_sat_i
);

    logic accept;

    assign accept = en_i & tvalid_i;

    // quiet while in reset and right after release
    a_reset_low : assert property (@(posedge clk_i) $past(!rstn_i) |-> !out_valid_i)
        else $error("output valid high during reset");

    a_after_reset : assert property (@(posedge clk_i) $past(!rstn_i, 2) |-> !out_valid_i)
        else $error("output valid high in the first cycle after reset");

    a_latency : assert property (@(posedge clk_i) disable iff (!rstn_i)
        $past(accept, LATENCY) |-> out_valid_i)
        else $error("accepted sample produced no output after %0d cycles", LATENCY);

    a_no_orphan : assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_i |-> $past(accept, LATENCY))
        else $error("output valid without a sample accepted %0d cycles before", LATENCY);

    a_sat_valid : assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_sat_i |-> out_valid_i)
        else $error("clip flag high without output valid");

endmodule

bind fir_top fir_assertions u_fir_assertions (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .en_i       (en_i),
    .tvalid_i   (tvalid_i),
    .out_valid_i(tvalid_o),
    .out_sat_i  (sat_o)
);

// File: sim/fir_tb.sv
// FIR subsystem testbench
// reads samples and expected results from the input file, drives them
// with randomised idle gaps and checks every output of fir_top in order

`timescale 1ns/10ps

module fir_tb
    import fir_pkg::*;
();

    localparam string       INPUT_FILE    = "sim/fir_input.txt";
    localparam int          RST_CYCLES    = 16;
    localparam int          LATENCY       = 6;    // accepting edge to tvalid_o
    localparam int          DRAIN_TIMEOUT = 100;  // cycles
    localparam int          HIST_SAMPLES  = 3;    // reset cuts them off before the output
    localparam int          HIST_VALUE    = 20000;
    localparam logic [31:0] LFSR_SEED     = 32'hab45;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    logic                       clk;
    logic                       rstn;
    logic                       en;
    logic                       tvalid_in;
    logic signed [SAMPLE_W-1:0] tdata_in;
    logic                       tvalid_out;
    logic signed [SAMPLE_W-1:0] tdata_out;
    logic                       sat_out;

    logic [31:0] lfsr_state;
    int          exp_data_q[$];
    int          exp_sat_q[$];
    int          n_accepted = 0;
    int          n_outputs  = 0;
    int          n_checks   = 0;
    int          val_errs   = 0;
    int          other_errs = 0;

    fir_top u_fir_top (
        .clk_i   (clk),
        .rstn_i  (rstn),
        .en_i    (en),
        .tvalid_i(tvalid_in),
        .tdata_i (tdata_in),
        .tvalid_o(tvalid_out),
        .tdata_o (tdata_out),
        .sat_o   (sat_out)
    );

    always #50 clk = ~clk;

    // one bit per step, galois form
    function automatic bit lfsr_bit();
        bit out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    task automatic check(input string what, input integer actual, input integer expected);
        n_checks++;
        if (actual !== expected) begin
            val_errs++;
            $display("error %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic drive_line(input int en_v, input int vld_v, input int smp_v,
                              input int exp_d, input int exp_s);
        @(posedge clk);
        en        <= en_v[0];
        tvalid_in <= vld_v[0];
        tdata_in  <= SAMPLE_W'(smp_v);
        if (en_v != 0 && vld_v != 0) begin
            exp_data_q.push_back(exp_d);
            exp_sat_q.push_back(exp_s);
            n_accepted++;
        end
    endtask

    // 0 to 3 cycles with valid low between file lines
    task automatic idle_gap();
        bit b1;
        bit b0;
        int gap;
        b1  = lfsr_bit();
        b0  = lfsr_bit();
        gap = 2 * int'(b1) + int'(b0);
        repeat (gap) begin
            @(posedge clk);
            tvalid_in <= 1'b0;
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        while (exp_data_q.size() != 0 && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_data_q.size() != 0) begin
            other_errs++;
            $display("timeout after %0d cycles, %0d expected outputs never arrived",
                     max_cycles, exp_data_q.size());
            exp_data_q.delete();
            exp_sat_q.delete();
        end
    endtask

    // let the pipeline empty, load some history for the reset to clear,
    // then reset in the middle of the stream
    task automatic pulse_reset();
        @(posedge clk);
        en        <= 1'b0;
        tvalid_in <= 1'b0;
        wait_drain(DRAIN_TIMEOUT);
        repeat (HIST_SAMPLES) begin
            @(posedge clk);
            en        <= 1'b1;
            tvalid_in <= 1'b1;
            tdata_in  <= SAMPLE_W'(HIST_VALUE);
        end
        @(posedge clk);
        en        <= 1'b0;
        tvalid_in <= 1'b0;
        rstn      <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    endtask

    // outputs are sampled away from the active edge
    always @(negedge clk) begin
        if (tvalid_out === 1'b1) begin
            n_outputs++;
            if (exp_data_q.size() == 0) begin
                other_errs++;
                $display("unexpected output %0d at %0t with no accepted sample left",
                         tdata_out, $time);
            end else begin
                check("output sample", 32'(tdata_out), exp_data_q.pop_front());
                check("saturation flag", 32'(sat_out), exp_sat_q.pop_front());
            end
        end
    end

    initial begin
        int    fd;
        int    n_read;
        int    n_fields;
        int    en_v;
        int    vld_v;
        int    smp_v;
        int    exp_d;
        int    exp_s;
        string line;

        $timeformat(-9, 0, " ns", 0);
        clk        = 1'b0;
        rstn       = 1'b0;
        en         = 1'b0;
        tvalid_in  = 1'b0;
        tdata_in   = '0;
        lfsr_state = LFSR_SEED;

        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open %s, no stimulus was applied", INPUT_FILE);
        end else begin
            while (!$feof(fd)) begin
                n_read = $fgets(line, fd);
                if (n_read == 0) begin
                    break;
                end
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                n_fields = $sscanf(line, "%d %d %d %d %d", en_v, vld_v, smp_v, exp_d, exp_s);
                if (n_fields != 5) begin
                    other_errs++;
                    $display("malformed line in %s: %s", INPUT_FILE, line);
                end else if (en_v == 2) begin
                    pulse_reset();
                end else begin
                    drive_line(en_v, vld_v, smp_v, exp_d, exp_s);
                    idle_gap();
                end
            end
            $fclose(fd);
        end

        @(posedge clk);
        tvalid_in <= 1'b0;
        wait_drain(DRAIN_TIMEOUT);
        repeat (LATENCY + 4) @(negedge clk);  // catch outputs nobody asked for

        check("output count", n_outputs, n_accepted);
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/fir_input.txt
# columns: en valid sample expected_output expected_sat (decimal)
# en = 2 pulses a reset; expected columns only count when en and valid are 1
# impulse of full scale after reset
1 1 32767 600 0
1 1 0 -1700 0
1 1 0 4900 0
1 1 0 12400 0
1 1 0 12400 0
1 1 0 4900 0
1 1 0 -1700 0
1 1 0 600 0
# constant 10000 ramps up and settles
1 1 10000 183 0
1 1 10000 -336 0
1 1 10000 1160 0
1 1 10000 4944 0
1 1 10000 8728 0
1 1 10000 10223 0
1 1 10000 9705 0
1 1 10000 9888 0
1 1 10000 9888 0
1 1 10000 9888 0
1 1 10000 9888 0
1 1 10000 9888 0
# samples with en low are dropped
0 1 -20000 0 0
0 1 30000 0 0
1 1 0 9705 0
0 0 0 0 0
0 1 -32768 0 0
1 1 0 10223 0
1 1 0 8728 0
0 1 12345 0 0
1 1 0 4944 0
1 1 0 1160 0
1 0 500 0 0
1 1 0 -336 0
1 1 0 183 0
1 1 0 0 0
# reset, then full-scale pattern matched to coefficient signs
2 0 0 0 0
1 1 32767 600 0
1 1 -32768 -2300 0
1 1 32767 7200 0
1 1 32767 6400 0
1 1 32767 3800 0
1 1 32767 8699 0
1 1 -32768 20799 0
1 1 32767 32767 1
1 1 -32768 20199 0
1 1 32767 10999 0
1 1 -32768 -3400 0
1 1 -32768 0 0
1 1 -32768 3399 0
1 1 -32768 -11000 0
1 1 32767 -20200 0
1 1 -32768 -32768 1
1 1 0 -20800 0
1 1 0 -8700 0
1 1 0 -3800 0
1 1 0 -6400 0
1 1 0 -7200 0
1 1 0 2300 0
1 1 0 -600 0
1 1 0 0 0

// File: compile.f
rtl/fir_pkg.sv
rtl/shift_reg.sv
rtl/fir_filter.sv
rtl/fir_requant.sv
rtl/fir_top.sv
sim/fir_assertions.sv
sim/fir_tb.sv

// File: Makefile
# Verilator build and run for the FIR subsystem
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= fir_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "pass message found in $(LOG)"; \
	else \
		echo "pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
